// File: design/mipsIsaPkg.sv
package mipsIsaPkg;

    // Primary opcodes
    localparam logic [5:0] opRtype = 6'h00;
    localparam logic [5:0] opJ     = 6'h02;
    localparam logic [5:0] opJal   = 6'h03;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] opAddi  = 6'h08;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opOri   = 6'h0d;
    localparam logic [5:0] opLui   = 6'h0f;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;

    // Funct codes under opRtype
    localparam logic [5:0] fnJr   = 6'h08;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnSlt  = 6'h2a;

    localparam logic [4:0] regFlag = 5'd30;
    localparam logic [4:0] regRet  = 5'd31;

    // Immediate is bits 15:0, jump index is bits 25:0
    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instrFields;

endpackage

// File: design/mipsCorePkg.sv
package mipsCorePkg;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluOr,
        aluSlt,
        aluLui
    } aluOp;

    typedef struct packed {
        logic regWrite;
        logic regDstRd;
        logic regDstRa;
        logic aluSrcImm;
        logic immSigned;
        aluOp aluSel;
        logic memRead;
        logic memWrite;
        logic branch;
        logic jump;
        logic jumpReg;
        logic link;
        logic trapOverflow;
    } ctrlWord;

    // One retired instruction
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        regWe;
        logic [4:0]  regAddr;
        logic [31:0] regData;
        logic        memWe;
        logic [31:0] memAddr;
        logic [31:0] memData;
    } commitInfo;

    localparam logic [31:0] resetPc = 32'h0000_3000;

endpackage

// File: design/controlDecoder.sv
module controlDecoder (
    input  mipsIsaPkg::instrFields instr,
    output mipsCorePkg::ctrlWord   ctrl
);
    import mipsIsaPkg::*;
    import mipsCorePkg::*;

    always_comb begin
        // Unknown encodings fall through as a no-op
        ctrl = '0;
        case (instr.op)
            opRtype: begin
                case (instr.funct)
                    fnAddu: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.regDstRd = 1'b1;
                        ctrl.aluSel   = aluAdd;
                    end
                    fnSubu: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.regDstRd = 1'b1;
                        ctrl.aluSel   = aluSub;
                    end
                    fnSlt: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.regDstRd = 1'b1;
                        ctrl.aluSel   = aluSlt;
                    end
                    fnJr: ctrl.jumpReg = 1'b1;
                    default: ctrl = '0;
                endcase
            end
            opAddi, opAddiu, opLw: begin
                ctrl.regWrite     = 1'b1;
                ctrl.aluSrcImm    = 1'b1;
                ctrl.immSigned    = 1'b1;
                ctrl.aluSel       = aluAdd;
                ctrl.trapOverflow = (instr.op == opAddi);
                ctrl.memRead      = (instr.op == opLw);
            end
            opOri: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluSel    = aluOr;
            end
            opLui: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluSel    = aluLui;
            end
            opSw: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.immSigned = 1'b1;
                ctrl.aluSel    = aluAdd;
                ctrl.memWrite  = 1'b1;
            end
            opBeq: ctrl.branch = 1'b1;
            opJ:   ctrl.jump   = 1'b1;
            opJal: begin
                ctrl.jump     = 1'b1;
                ctrl.link     = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.regDstRa = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

// File: design/instrFetch.sv
module instrFetch #(
    parameter int ImemWords = 64
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        run,
    input  logic        takeBranch,
    input  logic        jump,
    input  logic        jumpReg,
    input  logic [31:0] regTarget,
    input  logic        progWe,
    input  logic [31:0] progAddr,
    input  logic [31:0] progData,
    output logic [31:0] pc,
    output logic [31:0] instr
);
    import mipsCorePkg::*;

    localparam int IdxW = $clog2(ImemWords);

    logic [31:0] imem [ImemWords];
    logic [31:0] pcPlus4;
    logic [31:0] branchOffset;
    logic [31:0] nextPc;

    assign pcPlus4      = pc + 32'd4;
    assign branchOffset = {{14{instr[15]}}, instr[15:0], 2'b00};

    always_comb begin
        if (jumpReg) begin
            nextPc = regTarget;
        end else if (jump) begin
            nextPc = {pcPlus4[31:28], instr[25:0], 2'b00};
        end else if (takeBranch) begin
            nextPc = pcPlus4 + branchOffset;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= resetPc;
        end else if (run) begin
            pc <= nextPc;
        end
    end

    // progAddr is a byte address with the same word mapping as the PC
    always_ff @(posedge clk) begin
        if (progWe) begin
            imem[progAddr[IdxW+1:2]] <= progData;
        end
    end

    // Word index wraps at the memory depth
    assign instr = imem[pc[IdxW+1:2]];

endmodule

// File: design/registerFile.sv
module registerFile (
    input  logic        clk,
    input  logic        rstN,
    input  logic        we,
    input  logic [4:0]  raddrA,
    input  logic [4:0]  raddrB,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata,
    output logic [31:0] rdataA,
    output logic [31:0] rdataB
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // Register 0 is hardwired to zero
    assign rdataA = (raddrA == 5'd0) ? 32'd0 : regs[raddrA];
    assign rdataB = (raddrB == 5'd0) ? 32'd0 : regs[raddrB];

endmodule

// File: design/aluUnit.sv
module aluUnit (
    input  mipsCorePkg::aluOp op,
    input  logic [31:0]       a,
    input  logic [31:0]       b,
    output logic [31:0]       result,
    output logic              overflow
);
    import mipsCorePkg::*;

    logic [31:0] sum;
    logic [31:0] diff;
    logic        lessSigned;

    assign sum        = a + b;
    assign diff       = a - b;
    assign lessSigned = $signed(a) < $signed(b);

    // Same-sign operands giving a result of the other sign
    assign overflow = (a[31] == b[31]) && (sum[31] != a[31]);

    always_comb begin
        case (op)
            aluAdd:  result = sum;
            aluSub:  result = diff;
            aluOr:   result = a | b;
            aluSlt:  result = {31'd0, lessSigned};
            aluLui:  result = {b[15:0], 16'd0};
            default: result = sum;
        endcase
    end

endmodule

// File: design/dataMemory.sv
module dataMemory #(
    parameter int DmemWords = 64
) (
    input  logic        clk,
    input  logic        we,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata
);

    localparam int IdxW = $clog2(DmemWords);

    logic [31:0]     mem [DmemWords];
    logic [IdxW-1:0] wordIdx;

    // Word address, wraps at the memory depth
    assign wordIdx = addr[IdxW+1:2];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wordIdx] <= wdata;
        end
    end

    assign rdata = mem[wordIdx];

endmodule

// File: design/mipsCore.sv
module mipsCore #(
    parameter int ImemWords = 64,
    parameter int DmemWords = 64
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   run,
    input  logic                   progWe,
    input  logic [31:0]            progAddr,
    input  logic [31:0]            progData,
    output mipsCorePkg::commitInfo commit
);
    import mipsIsaPkg::*;
    import mipsCorePkg::*;

    instrFields  instr;
    ctrlWord     ctrl;
    logic [31:0] pc;
    logic [31:0] pcPlus4;
    logic [31:0] rsVal;
    logic [31:0] rtVal;
    logic [31:0] immExt;
    logic [31:0] aluB;
    logic [31:0] aluResult;
    logic        aluOverflow;
    logic [31:0] memRdata;
    logic        takeBranch;
    logic        trapHit;
    logic [4:0]  wbAddr;
    logic [31:0] wbData;
    logic        retire;
    logic        regWeEff;
    logic        memWeEff;

    instrFetch #(.ImemWords(ImemWords)) fetch (
        .clk(clk), .rstN(rstN), .run(run),
        .takeBranch(takeBranch), .jump(ctrl.jump), .jumpReg(ctrl.jumpReg),
        .regTarget(rsVal),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .pc(pc), .instr(instr)
    );

    controlDecoder decoder (.instr(instr), .ctrl(ctrl));

    registerFile regs (
        .clk(clk), .rstN(rstN), .we(regWeEff),
        .raddrA(instr.rs), .raddrB(instr.rt), .waddr(wbAddr), .wdata(wbData),
        .rdataA(rsVal), .rdataB(rtVal)
    );

    assign immExt = ctrl.immSigned ? {{16{instr[15]}}, instr[15:0]} : {16'd0, instr[15:0]};
    assign aluB   = ctrl.aluSrcImm ? immExt : rtVal;

    aluUnit alu (.op(ctrl.aluSel), .a(rsVal), .b(aluB), .result(aluResult),
        .overflow(aluOverflow));

    dataMemory #(.DmemWords(DmemWords)) dmem (
        .clk(clk), .we(memWeEff), .addr(aluResult), .wdata(rtVal), .rdata(memRdata)
    );

    assign pcPlus4    = pc + 32'd4;
    assign takeBranch = ctrl.branch && (rsVal == rtVal);
    // Overflowing addi goes to the flag register instead
    assign trapHit    = ctrl.trapOverflow && aluOverflow;

    always_comb begin
        if (ctrl.regDstRa) begin
            wbAddr = regRet;
        end else if (trapHit) begin
            wbAddr = regFlag;
        end else if (ctrl.regDstRd) begin
            wbAddr = instr.rd;
        end else begin
            wbAddr = instr.rt;
        end
    end

    always_comb begin
        if (ctrl.link) begin
            wbData = pcPlus4;
        end else if (trapHit) begin
            wbData = 32'd1;
        end else if (ctrl.memRead) begin
            wbData = memRdata;
        end else begin
            wbData = aluResult;
        end
    end

    // Nothing retires while reset is held
    assign retire   = run && rstN;
    assign regWeEff = retire && ctrl.regWrite && (wbAddr != 5'd0);
    assign memWeEff = retire && ctrl.memWrite;

    always_comb begin
        commit.valid   = retire;
        commit.pc      = pc;
        commit.regWe   = regWeEff;
        commit.regAddr = wbAddr;
        commit.regData = wbData;
        commit.memWe   = memWeEff;
        commit.memAddr = aluResult;
        commit.memData = rtVal;
    end

endmodule

// File: testbench/mipsCore_props.sv
module mipsCore_props (
    input logic                   clk,
    input logic                   rstN,
    input mipsCorePkg::commitInfo commit
);
    timeunit 1ns;
    timeprecision 1ps;

    int failures = 0;

    validLowInReset: assert property (@(posedge clk) !rstN |-> !commit.valid)
        else begin
            failures++;
            $error("commit valid while reset is asserted");
        end

    // Writes to r0 are dropped before they reach the commit record
    noZeroRegWrite: assert property (@(posedge clk) disable iff (!rstN)
        commit.valid && commit.regWe |-> commit.regAddr != 5'd0)
        else begin
            failures++;
            $error("commit shows a register write to r0");
        end

    singleWriteKind: assert property (@(posedge clk) disable iff (!rstN)
        !(commit.regWe && commit.memWe))
        else begin
            failures++;
            $error("commit shows a register write and a memory write together");
        end

endmodule

bind mipsCore mipsCore_props props (.clk(clk), .rstN(rstN), .commit(commit));

// File: testbench/mipsCoreTb.sv
module mipsCoreTb;
    timeunit 1ns;
    timeprecision 1ps;
    import mipsIsaPkg::*;
    import mipsCorePkg::*;

    localparam int ImemWords = 64;
    localparam int DmemWords = 64;

    logic        clk = 1'b0;
    logic        rstN;
    logic        run;
    logic        progWe;
    logic [31:0] progAddr;
    logic [31:0] progData;
    commitInfo   commit;

    logic [31:0] progMem [ImemWords];
    logic [31:0] modelRegs [32];
    logic [31:0] modelDmem [DmemWords];
    logic [31:0] modelPc;
    int          errors = 0;
    int          checks = 0;
    int          testStart = 0;

    mipsCore #(.ImemWords(ImemWords), .DmemWords(DmemWords)) uut (
        .clk(clk), .rstN(rstN), .run(run), .progWe(progWe),
        .progAddr(progAddr), .progData(progData), .commit(commit)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] rType(logic [4:0] rs, rt, rd, logic [5:0] fn);
        return {opRtype, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] iType(logic [5:0] op, logic [4:0] rs, rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Target is program word k above the reset address
    function automatic logic [31:0] jType(logic [5:0] op, int k);
        return {op, 26'(resetPc[27:2] + k)};
    endfunction

    function automatic logic [31:0] randomArith();
        logic [4:0]  rs = 5'($urandom);
        logic [4:0]  rt = 5'($urandom);
        logic [4:0]  rd = 5'($urandom);
        logic [15:0] imm = 16'($urandom);
        case ($urandom_range(5, 0))
            0: return rType(rs, rt, rd, fnAddu);
            1: return rType(rs, rt, rd, fnSubu);
            2: return rType(rs, rt, rd, fnSlt);
            3: return iType(opOri, rs, rt, imm);
            4: return iType(opLui, 5'd0, rt, imm);
            default: return iType(opAddiu, rs, rt, imm);
        endcase
    endfunction

    task automatic compareValue(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // run stays high through reset, the core must still not retire
    task automatic applyReset();
        @(posedge clk);
        #2;
        rstN = 1'b0;
        run  = 1'b1;
        repeat (4) @(posedge clk);
        #2;
        run  = 1'b0;
        rstN = 1'b1;
        modelPc = resetPc;
        foreach (modelRegs[i]) modelRegs[i] = '0;
    endtask

    // Unused slots hold ori to r0, which retires as a no-op
    task automatic clearProgram();
        foreach (progMem[i]) progMem[i] = iType(opOri, 5'd0, 5'd0, 16'(i));
    endtask

    task automatic loadProgram();
        @(posedge clk);
        #2;
        progWe = 1'b1;
        for (int i = 0; i < ImemWords; i++) begin
            progAddr = 32'(i * 4);
            progData = progMem[i];
            @(posedge clk);
            #2;
        end
        progWe = 1'b0;
    endtask

    task automatic waitValid();
        int waited = 0;
        @(negedge clk);
        while (commit.valid !== 1'b1 && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (commit.valid !== 1'b1) begin
            $display("Timeout: no valid commit appeared after run was raised");
            $display("Verification failed");
            $finish;
        end
    endtask

    task automatic checkCommit();
        logic [31:0] ins = progMem[(modelPc >> 2) % ImemWords];
        logic [31:0] rsv = modelRegs[ins[25:21]];
        logic [31:0] rtv = modelRegs[ins[20:16]];
        logic [31:0] sext = {{16{ins[15]}}, ins[15:0]};
        logic [31:0] pc4 = modelPc + 32'd4;
        logic [31:0] sum = rsv + sext;
        logic [31:0] nextPc = pc4;
        logic [31:0] expData = sum;
        logic [32:0] wide;
        logic [4:0]  expAddr = ins[20:16];
        logic        expWe = 1'b1;
        logic        expMemWe = 1'b0;
        case (ins[31:26])
            opRtype: begin
                expAddr = ins[15:11];
                case (ins[5:0])
                    fnAddu: expData = rsv + rtv;
                    fnSubu: expData = rsv - rtv;
                    fnSlt: expData = ($signed(rsv) < $signed(rtv)) ? 32'd1 : 32'd0;
                    fnJr: begin
                        expWe = 1'b0;
                        nextPc = rsv;
                    end
                    default: expWe = 1'b0;
                endcase
            end
            opAddi: begin
                wide = {rsv[31], rsv} + {sext[31], sext};
                if (wide[32] != wide[31]) begin
                    expAddr = regFlag;
                    expData = 32'd1;
                end
            end
            opAddiu: expData = sum;
            opOri: expData = rsv | {16'd0, ins[15:0]};
            opLui: expData = {ins[15:0], 16'd0};
            opLw: expData = modelDmem[(sum >> 2) % DmemWords];
            opSw: begin
                expWe = 1'b0;
                expMemWe = 1'b1;
            end
            opBeq: begin
                expWe = 1'b0;
                if (rsv == rtv) nextPc = pc4 + {sext[29:0], 2'b00};
            end
            opJ: begin
                expWe = 1'b0;
                nextPc = {pc4[31:28], ins[25:0], 2'b00};
            end
            opJal: begin
                expAddr = regRet;
                expData = pc4;
                nextPc = {pc4[31:28], ins[25:0], 2'b00};
            end
            default: expWe = 1'b0;
        endcase
        if (expAddr == 5'd0) expWe = 1'b0;
        compareValue("commit.valid", 32'(commit.valid), 32'd1);
        compareValue("commit.pc", commit.pc, modelPc);
        compareValue("commit.regWe", 32'(commit.regWe), 32'(expWe));
        compareValue("commit.memWe", 32'(commit.memWe), 32'(expMemWe));
        if (expWe) begin
            compareValue("commit.regAddr", 32'(commit.regAddr), 32'(expAddr));
            compareValue("commit.regData", commit.regData, expData);
            modelRegs[expAddr] = expData;
        end
        if (expMemWe) begin
            compareValue("commit.memAddr", commit.memAddr, sum);
            compareValue("commit.memData", commit.memData, rtv);
            modelDmem[(sum >> 2) % DmemWords] = rtv;
        end
        modelPc = nextPc;
    endtask

    task automatic runCommits(int count);
        @(posedge clk);
        #2;
        run = 1'b1;
        repeat (count) begin
            waitValid();
            checkCommit();
            @(posedge clk);
            #2;
        end
        run = 1'b0;
    endtask

    task automatic holdCheck(int cycles);
        repeat (cycles) begin
            @(negedge clk);
            compareValue("commit.valid", 32'(commit.valid), 32'd0);
            compareValue("commit.pc", commit.pc, modelPc);
        end
    endtask

    task automatic reportTest(string name);
        $display("Test %s finished with %0d mismatches", name, errors - testStart);
        testStart = errors;
    endtask

    initial begin
        rstN     = 1'b0;
        run      = 1'b0;
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        void'($urandom(89));

        foreach (progMem[i]) progMem[i] = randomArith();
        applyReset();
        loadProgram();
        runCommits(64);
        reportTest("arithmetic");

        // 0x7fffffff plus one traps, minus one fits
        clearProgram();
        progMem[0] = iType(opLui, 5'd0, 5'd1, 16'h7fff);
        progMem[1] = iType(opOri, 5'd1, 5'd1, 16'hffff);
        progMem[2] = iType(opAddi, 5'd1, 5'd2, 16'h0001);
        progMem[3] = iType(opAddi, 5'd1, 5'd3, 16'hffff);
        for (int i = 0; i < 8; i++) begin
            progMem[4 + 3 * i] = iType(opLui, 5'd0, 5'(4 + i), (i % 2) ? 16'h8000 : 16'h7fff);
            progMem[5 + 3 * i] = iType(opOri, 5'(4 + i), 5'(4 + i), 16'($urandom));
            progMem[6 + 3 * i] = iType(opAddi, 5'(4 + i), 5'(12 + i), 16'($urandom));
        end
        progMem[28] = rType(5'd2, 5'd0, 5'd20, fnAddu);
        applyReset();
        loadProgram();
        runCommits(29);
        reportTest("overflow");

        for (int i = 0; i < 16; i++) begin
            logic [4:0]  b;
            logic [4:0]  v;
            logic [15:0] off;
            b = 5'($urandom_range(14, 1));
            v = 5'($urandom_range(29, 15));
            off = 16'($urandom) & 16'hfffc;
            progMem[4 * i] = iType(opOri, 5'd0, b, 16'($urandom) & 16'hfffc);
            progMem[4 * i + 1] = iType(opOri, 5'd0, v, 16'($urandom));
            progMem[4 * i + 2] = iType(opSw, b, v, off);
            progMem[4 * i + 3] = iType(opLw, b, 5'($urandom_range(29, 1)), off);
        end
        applyReset();
        loadProgram();
        runCommits(64);
        reportTest("memory");

        clearProgram();
        progMem[0]  = iType(opOri, 5'd0, 5'd1, 16'd5);
        progMem[1]  = iType(opOri, 5'd0, 5'd2, 16'd5);
        progMem[2]  = iType(opBeq, 5'd1, 5'd2, 16'd1);
        progMem[3]  = iType(opOri, 5'd0, 5'd3, 16'h0bad);
        progMem[4]  = iType(opBeq, 5'd1, 5'd0, 16'd5);
        progMem[5]  = jType(opJal, 8);
        progMem[6]  = jType(opJ, 10);
        progMem[7]  = iType(opOri, 5'd0, 5'd3, 16'h0bad);
        progMem[8]  = iType(opOri, 5'd0, 5'd4, 16'h0044);
        progMem[9]  = rType(5'd31, 5'd0, 5'd0, fnJr);
        progMem[10] = rType(5'd4, 5'd1, 5'd5, fnAddu);
        progMem[11] = iType(opBeq, 5'd0, 5'd0, 16'hfff4);
        applyReset();
        loadProgram();
        runCommits(25);
        reportTest("control flow");

        applyReset();
        runCommits(6);
        holdCheck(6);
        runCommits(8);
        applyReset();
        runCommits(3);
        reportTest("halt and reset");

        errors += uut.props.failures;
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: mipsCore.f
design/mipsIsaPkg.sv
design/mipsCorePkg.sv
design/controlDecoder.sv
design/instrFetch.sv
design/registerFile.sv
design/aluUnit.sv
design/dataMemory.sv
design/mipsCore.sv
testbench/mipsCore_props.sv
testbench/mipsCoreTb.sv

// File: Bender.yml
package:
  name: mipsCore

sources:
  - design/mipsIsaPkg.sv
  - design/mipsCorePkg.sv
  - design/controlDecoder.sv
  - design/instrFetch.sv
  - design/registerFile.sv
  - design/aluUnit.sv
  - design/dataMemory.sv
  - design/mipsCore.sv
  - target: test
    files:
      - testbench/mipsCore_props.sv
      - testbench/mipsCoreTb.sv
